/* list.f */
src/cpuPkg.sv
src/pipePkg.sv
src/stageRegister.sv
src/operandBypass.sv
src/aluCore.sv
src/executeUnit.sv
verification/exeChecker.sv
verification/tbExecute.sv

/* src/aluCore.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////
// Integer ALU with HI/LO pair
////////////////////////////////////////
module aluCore
    import cpuPkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    input  word_t      a,
    input  word_t      b,
    input  aluOp_t     aluOp,
    input  wire  [4:0] shiftAmount,
    output word_t      aluResult
);

    // Multiply result registers
    word_t hi;
    word_t lo;

    // Full 64-bit products, both signednesses
    logic signed [63:0] signedProduct;
    logic        [63:0] unsignedProduct;

    // Shift count for the variable shifts
    logic [4:0] variableShift;

    assign signedProduct   = $signed(a) * $signed(b);
    assign unsignedProduct = {32'b0, a} * {32'b0, b};
    assign variableShift   = a[4:0];

    ////////////////////////////////////////
    // Combinational result
    ////////////////////////////////////////
    always_comb begin
        aluResult = '0;
        case (aluOp)
            // No overflow trap, signed and unsigned add the same way
            ADD, ADDU: begin
                aluResult = a + b;
            end
            SUB, SUBU: begin
                aluResult = a - b;
            end
            AND: begin
                aluResult = a & b;
            end
            OR: begin
                aluResult = a | b;
            end
            XOR: begin
                aluResult = a ^ b;
            end
            NOR: begin
                aluResult = ~(a | b);
            end
            // Set on less than, result is 0 or 1
            SLT: begin
                aluResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            SLTU: begin
                aluResult = (a < b) ? 32'd1 : 32'd0;
            end
            // Fixed shifts act on B by the instruction field
            SLL: begin
                aluResult = b << shiftAmount;
            end
            SRL: begin
                aluResult = b >> shiftAmount;
            end
            SRA: begin
                aluResult = $signed(b) >>> shiftAmount;
            end
            // Variable shifts act on B by the register in A
            SLLV: begin
                aluResult = b << variableShift;
            end
            SRLV: begin
                aluResult = b >> variableShift;
            end
            SRAV: begin
                aluResult = $signed(b) >>> variableShift;
            end
            // Immediate arrives in the low half of B
            LUI: begin
                aluResult = {b[15:0], 16'h0000};
            end
            MFHI: begin
                aluResult = hi;
            end
            MFLO: begin
                aluResult = lo;
            end
            // Base plus offset for loads and stores
            MEMADDR: begin
                aluResult = a + b;
            end
            // MULT, MULTU, MTHI and MTLO write no general register
            default: begin
                aluResult = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // HI/LO update
    ////////////////////////////////////////
    // Written on the edge that ends the instruction's EX cycle
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hi <= '0;
            lo <= '0;
        end else begin
            case (aluOp)
                MULT: begin
                    hi <= signedProduct[63:32];
                    lo <= signedProduct[31:0];
                end
                MULTU: begin
                    hi <= unsignedProduct[63:32];
                    lo <= unsignedProduct[31:0];
                end
                MTHI: begin
                    hi <= a;
                end
                MTLO: begin
                    lo <= a;
                end
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // Decode upstream must only issue codes from the table
    aluOpDefined: assert property (
        @(posedge CLK) disable iff (!RESET)
            !$isunknown(aluOp) && (aluOp <= MEMADDR)
    ) else $error("aluCore: undefined ALU operation %h", aluOp);

endmodule

`default_nettype wire

/* src/cpuPkg.sv */
`default_nettype none

////////////////////////////////////////
// Architectural sizes
////////////////////////////////////////
package cpuPkg;

    // Data path width of the integer core
    localparam int WORD_WIDTH = 32;

    // Number of bits in an architectural register number
    localparam int REG_INDEX_WIDTH = 5;

    // Register zero reads as zero and is never a forwarding target
    localparam logic [REG_INDEX_WIDTH-1:0] ZERO_REG = '0;

    // One data word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Architectural register number
    typedef logic [REG_INDEX_WIDTH-1:0] regIndex_t;

    ////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////
    // Codes are contiguous so that MEMADDR is the highest defined value
    typedef enum logic [5:0] {
        ADD     = 6'd0,
        ADDU    = 6'd1,
        SUB     = 6'd2,
        SUBU    = 6'd3,
        AND     = 6'd4,
        OR      = 6'd5,
        XOR     = 6'd6,
        NOR     = 6'd7,
        SLT     = 6'd8,
        SLTU    = 6'd9,
        // Shifts by the instruction's shift field
        SLL     = 6'd10,
        SRL     = 6'd11,
        SRA     = 6'd12,
        // Shifts by the low bits of operand A
        SLLV    = 6'd13,
        SRLV    = 6'd14,
        SRAV    = 6'd15,
        LUI     = 6'd16,
        // HI/LO group
        MULT    = 6'd17,
        MULTU   = 6'd18,
        MFHI    = 6'd19,
        MFLO    = 6'd20,
        MTHI    = 6'd21,
        MTLO    = 6'd22,
        // Load and store address sum
        MEMADDR = 6'd23
    } aluOp_t;

endpackage

`default_nettype wire

/* src/executeUnit.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////
// Execute stage top level
////////////////////////////////////////
module executeUnit
    import cpuPkg::*;
    import pipePkg::*;
#(
    parameter bit FORWARD_ENABLE = 1'b1
) (
    input  wire        CLK,
    input  wire        RESET,
    input  exeIssue_t  issue,
    input  bypass_t    memBypass,
    output exeResult_t result,
    output bypass_t    earlyBypass
);

    // Operand A, operand B and store data
    localparam int OPERAND_COUNT = 3;

    // Instruction now in EX
    exeIssue_t  current;
    exeResult_t nextResult;

    // Own EX/MEM register as first-priority source
    bypass_t exeBypass;

    // Per-operand forwarding inputs and resolved values
    regIndex_t readRegs  [OPERAND_COUNT];
    word_t     fallbacks [OPERAND_COUNT];
    word_t     resolved  [OPERAND_COUNT];

    word_t aluResult;

    // ID/EX register
    stageRegister #(
        .PAYLOAD_T(exeIssue_t)
    ) idExeReg (
        .CLK  (CLK),
        .RESET(RESET),
        .d    (issue),
        .q    (current)
    );

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////
    // Loads and stores in EX/MEM have no register result yet
    assign exeBypass.valid  = result.regWrite && !(result.memRead || result.memWrite);
    assign exeBypass.regNum = result.writeReg;
    assign exeBypass.data   = result.aluResult;

    // Index 2 resolves store data through its source register
    assign readRegs[0]  = current.regA;
    assign readRegs[1]  = current.regB;
    assign readRegs[2]  = current.writeReg;
    assign fallbacks[0] = current.operandA;
    assign fallbacks[1] = current.operandB;
    assign fallbacks[2] = current.storeData;

    for (genvar i = 0; i < OPERAND_COUNT; i++) begin : gBypass
        operandBypass #(
            .FORWARD_ENABLE(FORWARD_ENABLE)
        ) bypassUnit (
            .readReg     (readRegs[i]),
            .fallback    (fallbacks[i]),
            .firstSource (exeBypass),
            .secondSource(memBypass),
            .value       (resolved[i])
        );
    end

    aluCore alu (
        .CLK        (CLK),
        .RESET      (RESET),
        .a          (resolved[0]),
        .b          (resolved[1]),
        .aluOp      (current.aluOp),
        .shiftAmount(current.shiftAmount),
        .aluResult  (aluResult)
    );

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    assign nextResult.instr     = current.instr;
    assign nextResult.pc        = current.pc;
    assign nextResult.aluResult = aluResult;
    assign nextResult.writeReg  = current.writeReg;
    assign nextResult.storeData = resolved[2];
    assign nextResult.regWrite  = current.regWrite;
    assign nextResult.aluOp     = current.aluOp;
    assign nextResult.memRead   = current.memRead;
    assign nextResult.memWrite  = current.memWrite;

    stageRegister #(
        .PAYLOAD_T(exeResult_t)
    ) exeMemReg (
        .CLK  (CLK),
        .RESET(RESET),
        .d    (nextResult),
        .q    (result)
    );

    // Early bypass straight from the ALU, for the stage behind us
    assign earlyBypass.valid  = current.regWrite && !(current.memRead || current.memWrite);
    assign earlyBypass.regNum = current.writeReg;
    assign earlyBypass.data   = aluResult;

endmodule

`default_nettype wire

/* src/operandBypass.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////
// Two-priority operand forwarding
////////////////////////////////////////
module operandBypass
    import cpuPkg::*;
    import pipePkg::*;
#(
    parameter bit FORWARD_ENABLE = 1'b1
) (
    input  regIndex_t readReg,
    input  word_t     fallback,
    input  bypass_t   firstSource,
    input  bypass_t   secondSource,
    output word_t     value
);

    // Register zero is hard-wired and never takes a bypass
    logic forwardAllowed;
    logic firstHit;
    logic secondHit;

    assign forwardAllowed = FORWARD_ENABLE && (readReg != ZERO_REG);

    // A source hits when it is valid and targets the requested register
    assign firstHit  = firstSource.valid && (firstSource.regNum == readReg);
    assign secondHit = secondSource.valid && (secondSource.regNum == readReg);

    // Youngest result wins, so EX/MEM is checked before the memory stage
    always_comb begin
        value = fallback;
        if (forwardAllowed) begin
            if (firstHit) begin
                value = firstSource.data;
            end else if (secondHit) begin
                value = secondSource.data;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pipePkg.sv */
`default_nettype none

////////////////////////////////////////
// Pipeline stage payloads
////////////////////////////////////////
package pipePkg;

    import cpuPkg::*;

    // Decoded instruction as it leaves ID for EX
    typedef struct packed {
        // Debug words, carried along unchanged
        word_t     instr;
        word_t     pc;
        // Source register numbers, used only for forwarding
        regIndex_t regA;
        regIndex_t regB;
        // Operand values read from the register file in ID
        word_t     operandA;
        word_t     operandB;
        // Destination register, or the store data source register
        regIndex_t writeReg;
        word_t     storeData;
        // Control
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        aluOp_t    aluOp;
        logic [4:0] shiftAmount;
    } exeIssue_t;

    // Executed instruction as it leaves EX for MEM
    typedef struct packed {
        word_t     instr;
        word_t     pc;
        word_t     aluResult;
        regIndex_t writeReg;
        word_t     storeData;
        logic      regWrite;
        // Kept for the memory stage, which uses it to pick the access size
        aluOp_t    aluOp;
        logic      memRead;
        logic      memWrite;
    } exeResult_t;

    // One forwarding source
    typedef struct packed {
        logic      valid;
        regIndex_t regNum;
        word_t     data;
    } bypass_t;

endpackage

`default_nettype wire

/* src/stageRegister.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////
// Generic pipeline register
////////////////////////////////////////
// Serves any packed payload, one clock of delay
module stageRegister #(
    parameter type PAYLOAD_T = logic
) (
    input  wire      CLK,
    input  wire      RESET,
    input  PAYLOAD_T d,
    output PAYLOAD_T q
);

    // Whole payload clears on reset
    // Control bits inside it come out low, so the slot is a bubble
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

    // Upstream must never push X into the pipe once out of reset
    // Checked one edge late so the first sample after release is a cleared value
    property noUnknownAfterReset;
        @(posedge CLK) disable iff (!RESET)
            $past(RESET) |-> !$isunknown(q);
    endproperty

    qKnown: assert property (noUnknownAfterReset)
        else $error("stageRegister: unknown value on q");

endmodule

`default_nettype wire

/* verification/exeChecker.sv */
`timescale 1ns/10ps
`default_nettype none

// Watches the execute stage ports and predicts every output
module exeChecker
    import cpuPkg::*;
    import pipePkg::*;
#(
    parameter bit FORWARD_ENABLE = 1'b1
) (
    input  wire        CLK,
    input  wire        RESET,
    input  exeIssue_t  issue,
    input  bypass_t    memBypass,
    input  exeResult_t result,
    input  bypass_t    earlyBypass,
    // Hand-worked values from the stimulus table
    input  wire        expectValid,
    input  word_t      expectAlu,
    input  word_t      expectStore,
    output int         resultErrors,
    output int         bypassErrors,
    output int         tableErrors,
    output int         checkCount
);

    typedef struct packed {
        logic  valid;
        word_t alu;
        word_t store;
    } expect_t;

    // Two instructions in flight, one in EX and one in EX/MEM
    exeIssue_t  exStage;
    expect_t    exExpect;
    exeResult_t memStage;
    expect_t    memExpect;
    word_t      hiModel;
    word_t      loModel;

    // Scratch values of one cycle
    bypass_t    firstSource;
    bypass_t    predictedBypass;
    word_t      opA;
    word_t      opB;
    word_t      storeValue;
    word_t      aluValue;
    logic [63:0] product;

    // Forwarding priority, youngest source first
    function automatic word_t forward(regIndex_t r, word_t fb, bypass_t first, bypass_t second);
        if (!FORWARD_ENABLE || r == 5'd0) begin
            return fb;
        end
        if (first.valid && first.regNum == r) begin
            return first.data;
        end
        if (second.valid && second.regNum == r) begin
            return second.data;
        end
        return fb;
    endfunction

    // Arithmetic right shift through a sign-extended double word
    function automatic word_t shiftArith(word_t v, logic [4:0] n);
        logic [63:0] ext;
        ext = {{32{v[31]}}, v} >> n;
        return ext[31:0];
    endfunction

    function automatic word_t aluModel(aluOp_t op, word_t a, word_t b, logic [4:0] sh);
        case (op)
            ADD, ADDU, MEMADDR: return a + b;
            SUB, SUBU:          return a - b;
            AND:                return a & b;
            OR:                 return a | b;
            XOR:                return a ^ b;
            NOR:                return ~a & ~b;
            // Differing signs decide alone, else plain magnitude
            SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            SLTU: return {31'b0, a < b};
            SLL:  return b << sh;
            SRL:  return b >> sh;
            SRA:  return shiftArith(b, sh);
            SLLV: return b << a[4:0];
            SRLV: return b >> a[4:0];
            SRAV: return shiftArith(b, a[4:0]);
            LUI:  return b << 16;
            MFHI: return hiModel;
            MFLO: return loModel;
            default: return 32'h0;
        endcase
    endfunction

    initial begin
        resultErrors = 0;
        bypassErrors = 0;
        tableErrors  = 0;
        checkCount   = 0;
    end

    ////////////////////////////////////////
    // Per-cycle prediction and compare
    ////////////////////////////////////////
    always @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            exStage   = '0;
            exExpect  = '0;
            memStage  = '0;
            memExpect = '0;
            hiModel   = '0;
            loModel   = '0;
        end else begin
            // EX/MEM feeds back only plain register writes
            firstSource.valid  = memStage.regWrite && !memStage.memRead && !memStage.memWrite;
            firstSource.regNum = memStage.writeReg;
            firstSource.data   = memStage.aluResult;
            opA        = forward(exStage.regA, exStage.operandA, firstSource, memBypass);
            opB        = forward(exStage.regB, exStage.operandB, firstSource, memBypass);
            storeValue = forward(exStage.writeReg, exStage.storeData, firstSource, memBypass);
            aluValue   = aluModel(exStage.aluOp, opA, opB, exStage.shiftAmount);
            predictedBypass.valid  = exStage.regWrite && !exStage.memRead && !exStage.memWrite;
            predictedBypass.regNum = exStage.writeReg;
            predictedBypass.data   = aluValue;
            checkCount = checkCount + 1;
            if (earlyBypass !== predictedBypass) begin
                bypassErrors = bypassErrors + 1;
                $display("FAILED earlyBypass expected %h actual %h", predictedBypass, earlyBypass);
            end
            if (result !== memStage) begin
                resultErrors = resultErrors + 1;
                $display("FAILED result expected %h actual %h", memStage, result);
            end
            if (memExpect.valid && result.aluResult !== memExpect.alu) begin
                tableErrors = tableErrors + 1;
                $display("FAILED result.aluResult expected %h actual %h",
                         memExpect.alu, result.aluResult);
            end
            if (memExpect.valid && result.storeData !== memExpect.store) begin
                tableErrors = tableErrors + 1;
                $display("FAILED result.storeData expected %h actual %h",
                         memExpect.store, result.storeData);
            end
            // HI/LO change at the end of the EX cycle
            case (exStage.aluOp)
                MULT: begin
                    product = {{32{opA[31]}}, opA} * {{32{opB[31]}}, opB};
                    {hiModel, loModel} = product;
                end
                MULTU: begin
                    product = {32'h0, opA} * {32'h0, opB};
                    {hiModel, loModel} = product;
                end
                MTHI: hiModel = opA;
                MTLO: loModel = opA;
                default: ;
            endcase
            // Advance the model pipe
            memStage.instr     = exStage.instr;
            memStage.pc        = exStage.pc;
            memStage.aluResult = aluValue;
            memStage.writeReg  = exStage.writeReg;
            memStage.storeData = storeValue;
            memStage.regWrite  = exStage.regWrite;
            memStage.aluOp     = exStage.aluOp;
            memStage.memRead   = exStage.memRead;
            memStage.memWrite  = exStage.memWrite;
            memExpect = exExpect;
            exStage   = issue;
            exExpect  = {expectValid, expectAlu, expectStore};
        end
    end

endmodule

`default_nettype wire

/* verification/tbExecute.sv */
`timescale 1ns/10ps
`default_nettype none

module tbExecute
    import cpuPkg::*;
    import pipePkg::*;
();

    localparam bit      FORWARD_ENABLE = 1'b1;
    localparam int      CLOCK_PERIOD   = 20;
    localparam int      RESET_CYCLES   = 8;
    localparam int      TABLE_ROWS     = 37;
    localparam int      RANDOM_COUNT   = 200;
    localparam bypass_t NO_BYPASS      = '0;

    // One directed step with the bypass it meets in EX
    typedef struct packed {
        exeIssue_t issue;
        bypass_t   mem;
        word_t     alu;
        word_t     store;
    } tableRow_t;

    logic       CLK;
    logic       RESET;
    exeIssue_t  issue;
    bypass_t    memBypass;
    exeResult_t result;
    bypass_t    earlyBypass;
    logic       expectValid;
    word_t      expectAlu;
    word_t      expectStore;
    int         resultErrors;
    int         bypassErrors;
    int         tableErrors;
    int         checkCount;
    tableRow_t  rows [TABLE_ROWS];
    int         rowCount;
    int         k;
    logic [31:0] lfsrState;

    always #(CLOCK_PERIOD / 2) CLK = ~CLK;

    executeUnit #(
        .FORWARD_ENABLE(FORWARD_ENABLE)
    ) executeUnit_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .issue      (issue),
        .memBypass  (memBypass),
        .result     (result),
        .earlyBypass(earlyBypass)
    );

    exeChecker #(
        .FORWARD_ENABLE(FORWARD_ENABLE)
    ) exeCheck (
        .CLK         (CLK),
        .RESET       (RESET),
        .issue       (issue),
        .memBypass   (memBypass),
        .result      (result),
        .earlyBypass (earlyBypass),
        .expectValid (expectValid),
        .expectAlu   (expectAlu),
        .expectStore (expectStore),
        .resultErrors(resultErrors),
        .bypassErrors(bypassErrors),
        .tableErrors (tableErrors),
        .checkCount  (checkCount)
    );

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // Small register numbers so that sources collide often
    task automatic makeRandomIssue(input int n, output exeIssue_t v);
        word_t t;
        v = '0;
        v.pc = 32'h0050_0000 + 4 * n;
        takeBits(32, t);
        v.instr = t;
        takeBits(2, t);
        v.regA = t[4:0];
        takeBits(2, t);
        v.regB = t[4:0];
        takeBits(32, t);
        v.operandA = t;
        takeBits(32, t);
        v.operandB = t;
        takeBits(2, t);
        v.writeReg = t[4:0];
        takeBits(32, t);
        v.storeData = t;
        takeBits(3, t);
        {v.regWrite, v.memRead, v.memWrite} = t[2:0];
        takeBits(5, t);
        v.aluOp = aluOp_t'(6'(t % 24));
        takeBits(5, t);
        v.shiftAmount = t[4:0];
    endtask

    task automatic makeRandomBypass(output bypass_t v);
        word_t t;
        takeBits(1, t);
        v.valid = t[0];
        takeBits(2, t);
        v.regNum = t[4:0];
        takeBits(32, t);
        v.data = t;
    endtask

    ////////////////////////////////////////
    // Directed table
    ////////////////////////////////////////
    task automatic addRow(input aluOp_t op, input regIndex_t rA, input word_t a,
                          input regIndex_t rB, input word_t b, input regIndex_t wr,
                          input word_t sd, input logic [2:0] ctrl, input logic [4:0] sh,
                          input bypass_t mb, input word_t expAlu, input word_t expStore);
        tableRow_t row;
        row.issue.instr = 32'ha500_0000 | rowCount;
        row.issue.pc = 32'h0040_0000 + 4 * rowCount;
        row.issue.regA = rA;
        row.issue.operandA = a;
        row.issue.regB = rB;
        row.issue.operandB = b;
        row.issue.writeReg = wr;
        row.issue.storeData = sd;
        {row.issue.regWrite, row.issue.memRead, row.issue.memWrite} = ctrl;
        row.issue.aluOp = op;
        row.issue.shiftAmount = sh;
        row.mem = mb;
        row.alu = expAlu;
        row.store = expStore;
        rows[rowCount] = row;
        rowCount = rowCount + 1;
    endtask

    // Plain operation without forwarding that writes only when a destination is given
    task automatic addAlu(input aluOp_t op, input word_t a, input word_t b,
                          input logic [4:0] sh, input regIndex_t wr, input word_t expAlu);
        addRow(op, 5'd0, a, 5'd0, b, wr, 32'h0, (wr != 5'd0) ? 3'b100 : 3'b000, sh,
               NO_BYPASS, expAlu, 32'h0);
    endtask

    task automatic buildTable();
        // HI and LO read back cleared after reset
        addAlu(MFHI,  32'h0, 32'h0, 5'd0, 5'd23, 32'h0);
        addAlu(MFLO,  32'h0, 32'h0, 5'd0, 5'd24, 32'h0);
        addAlu(ADD,   32'd7, 32'd5, 5'd0, 5'd1, 32'h0000_000c);
        addAlu(ADDU,  32'hffff_ffff, 32'd2, 5'd0, 5'd2, 32'h0000_0001);
        addAlu(SUB,   32'd5, 32'd7, 5'd0, 5'd3, 32'hffff_fffe);
        addAlu(SUBU,  32'h100, 32'd1, 5'd0, 5'd4, 32'h0000_00ff);
        addAlu(AND,   32'hf0f0_f0f0, 32'hff00_ff00, 5'd0, 5'd5, 32'hf000_f000);
        addAlu(OR,    32'hf0f0_f0f0, 32'h0f0f_0000, 5'd0, 5'd6, 32'hffff_f0f0);
        addAlu(XOR,   32'hf0f0_f0f0, 32'hff00_ff00, 5'd0, 5'd7, 32'h0ff0_0ff0);
        addAlu(NOR,   32'h0f0f_0f0f, 32'hf0f0_0000, 5'd0, 5'd8, 32'h0000_f0f0);
        // Minus one is below one only when signed
        addAlu(SLT,   32'hffff_ffff, 32'd1, 5'd0, 5'd9, 32'h1);
        addAlu(SLTU,  32'hffff_ffff, 32'd1, 5'd0, 5'd10, 32'h0);
        addAlu(SLL,   32'h0, 32'h3, 5'd4, 5'd11, 32'h0000_0030);
        addAlu(SRL,   32'h0, 32'h8000_0000, 5'd4, 5'd12, 32'h0800_0000);
        addAlu(SRA,   32'h0, 32'h8000_0000, 5'd4, 5'd13, 32'hf800_0000);
        addAlu(SLLV,  32'h8, 32'h1, 5'd0, 5'd14, 32'h0000_0100);
        addAlu(SRLV,  32'h24, 32'hf000_0000, 5'd0, 5'd15, 32'h0f00_0000);
        addAlu(SRAV,  32'h1f, 32'h8000_0000, 5'd0, 5'd16, 32'hffff_ffff);
        addAlu(LUI,   32'h0, 32'h1234, 5'd0, 5'd17, 32'h1234_0000);
        // HI/LO group with minus two times three
        addAlu(MULT,  32'hffff_fffe, 32'd3, 5'd0, 5'd0, 32'h0);
        addAlu(MFHI,  32'h0, 32'h0, 5'd0, 5'd18, 32'hffff_ffff);
        addAlu(MFLO,  32'h0, 32'h0, 5'd0, 5'd19, 32'hffff_fffa);
        addAlu(MULTU, 32'hffff_ffff, 32'd2, 5'd0, 5'd0, 32'h0);
        addAlu(MFHI,  32'h0, 32'h0, 5'd0, 5'd20, 32'h0000_0001);
        addAlu(MTLO,  32'habcd_0123, 32'h0, 5'd0, 5'd0, 32'h0);
        addAlu(MFLO,  32'h0, 32'h0, 5'd0, 5'd21, 32'habcd_0123);
        addAlu(MTHI,  32'h5a5a_5a5a, 32'h0, 5'd0, 5'd0, 32'h0);
        addAlu(MFHI,  32'h0, 32'h0, 5'd0, 5'd22, 32'h5a5a_5a5a);
        // Back to back dependency where EX/MEM beats the memory stage
        addAlu(ADD,   32'h10, 32'h20, 5'd0, 5'd5, 32'h30);
        addRow(ADD, 5'd5, 32'h999, 5'd0, 32'h1, 5'd6, 32'h0, 3'b100, 5'd0,
               {1'b1, 5'd5, 32'hdead}, 32'h31, 32'h0);
        // Load in EX/MEM stays off the bypass
        addRow(MEMADDR, 5'd0, 32'h1000, 5'd0, 32'h8, 5'd7, 32'h0, 3'b110, 5'd0,
               NO_BYPASS, 32'h1008, 32'h0);
        addRow(ADD, 5'd0, 32'h1, 5'd7, 32'h0, 5'd8, 32'h0, 3'b100, 5'd0,
               {1'b1, 5'd7, 32'h55}, 32'h56, 32'h0);
        // Register zero keeps its fallback against both sources
        addRow(ADD, 5'd0, 32'h3, 5'd0, 32'h4, 5'd0, 32'h0, 3'b100, 5'd0,
               NO_BYPASS, 32'h7, 32'h0);
        addRow(ADD, 5'd0, 32'h11, 5'd0, 32'h22, 5'd9, 32'h0, 3'b100, 5'd0,
               {1'b1, 5'd0, 32'hbad}, 32'h33, 32'h0);
        // Store data through each source
        addAlu(ADD,   32'h40, 32'h2, 5'd0, 5'd10, 32'h42);
        addRow(MEMADDR, 5'd0, 32'h2000, 5'd0, 32'h10, 5'd10, 32'h0, 3'b001, 5'd0,
               NO_BYPASS, 32'h2010, 32'h42);
        addRow(MEMADDR, 5'd0, 32'h3000, 5'd0, 32'h4, 5'd11, 32'h77, 3'b001, 5'd0,
               {1'b1, 5'd11, 32'hcafe}, 32'h3004, 32'hcafe);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        CLK = 1'b0;
        RESET = 1'b0;
        issue = '0;
        memBypass = '0;
        expectValid = 1'b0;
        expectAlu = '0;
        expectStore = '0;
        lfsrState = 32'hfa97;
        rowCount = 0;
        buildTable();
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
        // Each row's bypass arrives one cycle late while that row sits in EX
        for (k = 0; k < rowCount + RANDOM_COUNT; k++) begin
            @(negedge CLK);
            if (k < rowCount) begin
                issue = rows[k].issue;
                expectValid = 1'b1;
                expectAlu = rows[k].alu;
                expectStore = rows[k].store;
            end else begin
                makeRandomIssue(k, issue);
                expectValid = 1'b0;
            end
            if (k >= 1 && k <= rowCount) begin
                memBypass = rows[k - 1].mem;
            end else begin
                makeRandomBypass(memBypass);
            end
        end
        // Drain the two stages behind the last instruction
        @(negedge CLK);
        issue = '0;
        memBypass = '0;
        expectValid = 1'b0;
        repeat (3) @(negedge CLK);
        $display("Checks %0d, result errors %0d, earlyBypass errors %0d, table errors %0d",
                 checkCount, resultErrors, bypassErrors, tableErrors);
        if (resultErrors + bypassErrors + tableErrors == 0 && checkCount > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TABLE_ROWS + RANDOM_COUNT + 20) * CLOCK_PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
